// File: rtl/owt_pkg.sv
// shared frame sizes, tail pattern, crc polynomial, error tables and fsm states for the receiver
package owt_pkg;

    // ====================
    // frame layout
    // ====================
    localparam int OWT_CMD_BITS    = 8;
    localparam int OWT_DATA_BITS   = 16;
    localparam int OWT_CRC_BITS    = 8;
    localparam int OWT_TAIL_SYMS   = 4;
    localparam int OWT_HEAD_PULSES = 4;

    // first tail symbol sits in the msb
    localparam logic [OWT_TAIL_SYMS-1:0] OWT_TAIL_PATTERN = 4'b0110;

    // read to this address has no data field
    localparam logic [OWT_CMD_BITS-2:0] OWT_RD_NODATA_ADDR = 7'h1F;

    // x^8 + x^2 + x + 1, start value zero
    localparam logic [OWT_CRC_BITS-1:0] OWT_CRC_POLY = 8'h07;

    // ====================
    // counter widths
    // ====================
    localparam int OWT_SYM_CNT_W = 8;
    localparam int OWT_BIT_CNT_W = 5;
    localparam int OWT_ERR_CNT_W = 4;

    // ====================
    // link error counter
    // ====================
    localparam logic [OWT_ERR_CNT_W-1:0] OWT_ERR_MAX  = 4'd15;
    localparam logic [OWT_ERR_CNT_W-1:0] OWT_ERR_INIT = 4'd15;

    // indexed by config[3:2]
    localparam logic [OWT_ERR_CNT_W-1:0] OWT_ERR_ADD_STEP [0:3] = '{
        4'd2, 4'd4, 4'd6, 4'd8
    };

    // indexed by config[1:0]
    localparam logic [OWT_ERR_CNT_W-1:0] OWT_COR_SUB_STEP [0:3] = '{
        4'd1, 4'd2, 4'd3, 4'd4
    };

    // receiver fsm
    typedef enum logic [2:0] {
        IDLE,
        SYNC_HEAD,
        SYNC_TAIL,
        CMD,
        DATA,
        CRC,
        END_TAIL
    } owt_rx_state_e;

endpackage

// File: rtl/owt_symbol_slicer.sv
// line synchronizer and half-bit slicer, measures symbol length from the sync head
module owt_symbol_slicer import owt_pkg::*; (
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_rx_line,
    input  logic i_head_phase,
    output logic o_rise,
    output logic o_fall,
    output logic o_sym_vld,
    output logic o_sym_level
);

    logic                     rx_meta;
    logic                     rx_sync;
    logic                     rx_lvl;
    logic                     rise_c;
    logic                     fall_c;
    logic                     head_d;
    logic [OWT_SYM_CNT_W-1:0] run_cnt;
    logic [OWT_SYM_CNT_W-1:0] sym_len;
    logic [OWT_SYM_CNT_W-1:0] thr;
    logic [OWT_SYM_CNT_W-1:0] reload;

    // ====================
    // sync and edges
    // ====================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rx_meta <= 1'b0;
            rx_sync <= 1'b0;
            rx_lvl  <= 1'b0;
            o_rise  <= 1'b0;
            o_fall  <= 1'b0;
        end else begin
            rx_meta <= i_rx_line;
            rx_sync <= rx_meta;
            rx_lvl  <= rx_sync;
            o_rise  <= rise_c;
            o_fall  <= fall_c;
        end
    end

    assign rise_c = rx_sync & ~rx_lvl;
    assign fall_c = ~rx_sync & rx_lvl;

    // ====================
    // symbol length
    // ====================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            head_d  <= 1'b0;
            sym_len <= '0;
        end else begin
            head_d <= i_head_phase;
            // new frame, forget the last length
            if (i_head_phase && !head_d) begin
                sym_len <= '0;
            end else if (fall_c && i_head_phase && (run_cnt > sym_len)) begin
                sym_len <= run_cnt;
            end
        end
    end

    // threshold is max(L-1, 2)
    assign thr    = (sym_len > OWT_SYM_CNT_W'(3)) ? sym_len - 1'b1 : OWT_SYM_CNT_W'(2);
    // next strobe lands L cycles later
    assign reload = thr - sym_len + 1'b1;

    // ====================
    // run counter
    // ====================
    // run_cnt is the cycle number within the current level, starting at 1
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            run_cnt <= '0;
        end else if (rise_c || fall_c) begin
            run_cnt <= OWT_SYM_CNT_W'(1);
        end else if (o_sym_vld) begin
            run_cnt <= reload;
        end else if (run_cnt != '1) begin
            run_cnt <= run_cnt + 1'b1;
        end
    end

    assign o_sym_vld   = (run_cnt == thr);
    assign o_sym_level = rx_lvl;

endmodule

// File: rtl/owt_crc8.sv
// serial crc-8, msb first, one bit per strobe with optional restart from zero
module owt_crc8 import owt_pkg::*; (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_bit_vld,
    input  logic                    i_bit,
    input  logic                    i_restart,
    output logic [OWT_CRC_BITS-1:0] o_crc
);

    logic [OWT_CRC_BITS-1:0] crc_base;
    logic [OWT_CRC_BITS-1:0] crc_nxt;
    logic                    fb;

    // restart folds the first bit into a zero register
    assign crc_base = i_restart ? '0 : o_crc;
    assign fb       = crc_base[OWT_CRC_BITS-1] ^ i_bit;

    always_comb begin
        crc_nxt = {crc_base[OWT_CRC_BITS-2:0], 1'b0};
        if (fb) begin
            crc_nxt = crc_nxt ^ OWT_CRC_POLY;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_crc <= '0;
        end else if (i_bit_vld) begin
            o_crc <= crc_nxt;
        end
    end

endmodule

// File: rtl/owt_frame_deserializer.sv
// frame fsm, pairs half-bit symbols into manchester bits and captures cmd, data and crc
module owt_frame_deserializer import owt_pkg::*; (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  logic                     i_rise,
    input  logic                     i_fall,
    input  logic                     i_sym_vld,
    input  logic                     i_sym_level,
    output logic                     o_head_phase,
    output logic [OWT_CMD_BITS-1:0]  o_cmd,
    output logic [OWT_DATA_BITS-1:0] o_data,
    output logic [OWT_CRC_BITS-1:0]  o_crc,
    output logic                     o_frame_done,
    output logic                     o_frame_status
);

    owt_rx_state_e            state_q;
    owt_rx_state_e            state_nxt;
    logic [OWT_BIT_CNT_W-1:0] bit_cnt;
    logic [OWT_BIT_CNT_W-1:0] cnt_last;
    logic                     cnt_evt;
    logic                     cnt_hit;
    logic                     in_bits;
    logic                     half_sel;
    logic                     first_lvl;
    logic                     bit_vld;
    logic                     bit_err;
    logic [OWT_TAIL_SYMS-1:0] tail_sr;
    logic [OWT_TAIL_SYMS-1:0] tail_nxt;
    logic [OWT_CMD_BITS-1:0]  cmd_nxt;
    logic                     cmd_nodata;
    logic                     crc_vld;
    logic                     crc_restart;
    logic [OWT_CRC_BITS-1:0]  crc_calc;
    logic                     frame_end;
    logic                     status_nxt;

    // ====================
    // manchester pairing
    // ====================
    assign in_bits = (state_q == CMD) || (state_q == DATA) || (state_q == CRC);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            half_sel <= 1'b0;
        end else if (!in_bits) begin
            half_sel <= 1'b0;
        end else if (i_sym_vld) begin
            half_sel <= ~half_sel;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_sym_vld && !half_sel) begin
            first_lvl <= i_sym_level;
        end
    end

    // high-low is a 1, low-high is a 0
    assign bit_vld = in_bits & i_sym_vld & half_sel & (first_lvl != i_sym_level);
    assign bit_err = in_bits & i_sym_vld & half_sel & (first_lvl == i_sym_level);

    // ====================
    // bit counter
    // ====================
    always_comb begin
        cnt_evt  = 1'b0;
        cnt_last = '0;
        case (state_q)
            SYNC_HEAD: begin
                cnt_evt  = i_fall;
                cnt_last = OWT_BIT_CNT_W'(OWT_HEAD_PULSES - 1);
            end
            SYNC_TAIL, END_TAIL: begin
                cnt_evt  = i_sym_vld;
                cnt_last = OWT_BIT_CNT_W'(OWT_TAIL_SYMS - 1);
            end
            CMD: begin
                cnt_evt  = bit_vld;
                cnt_last = OWT_BIT_CNT_W'(OWT_CMD_BITS - 1);
            end
            DATA: begin
                cnt_evt  = bit_vld;
                cnt_last = OWT_BIT_CNT_W'(OWT_DATA_BITS - 1);
            end
            CRC: begin
                cnt_evt  = bit_vld;
                cnt_last = OWT_BIT_CNT_W'(OWT_CRC_BITS - 1);
            end
            default: begin
                cnt_evt  = 1'b0;
                cnt_last = '0;
            end
        endcase
    end

    assign cnt_hit = cnt_evt & (bit_cnt == cnt_last);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            bit_cnt <= '0;
        end else if (state_nxt != state_q) begin
            bit_cnt <= '0;
        end else if (cnt_evt) begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    // ====================
    // fsm
    // ====================
    assign tail_nxt   = {tail_sr[OWT_TAIL_SYMS-2:0], i_sym_level};
    assign cmd_nxt    = {o_cmd[OWT_CMD_BITS-2:0], first_lvl};
    assign cmd_nodata = ~cmd_nxt[OWT_CMD_BITS-1] &
                        (cmd_nxt[OWT_CMD_BITS-2:0] == OWT_RD_NODATA_ADDR);

    always_comb begin
        state_nxt = state_q;
        case (state_q)
            IDLE: begin
                if (i_rise) begin
                    state_nxt = SYNC_HEAD;
                end
            end
            SYNC_HEAD: begin
                if (cnt_hit) begin
                    state_nxt = SYNC_TAIL;
                end
            end
            SYNC_TAIL: begin
                if (cnt_hit && (tail_nxt == OWT_TAIL_PATTERN)) begin
                    state_nxt = CMD;
                end else if (cnt_hit) begin
                    state_nxt = IDLE;
                end
            end
            CMD: begin
                if (bit_err) begin
                    state_nxt = IDLE;
                end else if (cnt_hit && cmd_nodata) begin
                    state_nxt = CRC;
                end else if (cnt_hit) begin
                    state_nxt = DATA;
                end
            end
            DATA: begin
                if (bit_err) begin
                    state_nxt = IDLE;
                end else if (cnt_hit) begin
                    state_nxt = CRC;
                end
            end
            CRC: begin
                if (bit_err) begin
                    state_nxt = IDLE;
                end else if (cnt_hit) begin
                    state_nxt = END_TAIL;
                end
            end
            END_TAIL: begin
                if (cnt_hit) begin
                    state_nxt = IDLE;
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_nxt;
        end
    end

    assign o_head_phase = (state_q == SYNC_HEAD);

    // ====================
    // field capture
    // ====================
    always_ff @(posedge i_clk) begin
        if (i_sym_vld && ((state_q == SYNC_TAIL) || (state_q == END_TAIL))) begin
            tail_sr <= tail_nxt;
        end
        if (bit_vld && (state_q == CMD)) begin
            o_cmd <= cmd_nxt;
        end
        if (bit_vld && (state_q == DATA)) begin
            o_data <= {o_data[OWT_DATA_BITS-2:0], first_lvl};
        end
        if (bit_vld && (state_q == CRC)) begin
            o_crc <= {o_crc[OWT_CRC_BITS-2:0], first_lvl};
        end
    end

    assign crc_vld     = bit_vld & ((state_q == CMD) || (state_q == DATA));
    assign crc_restart = (state_q == CMD) && (bit_cnt == '0);

    owt_crc8 crc_i (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_bit_vld (crc_vld),
        .i_bit     (first_lvl),
        .i_restart (crc_restart),
        .o_crc     (crc_calc)
    );

    // ====================
    // frame status
    // ====================
    assign frame_end  = (state_q != IDLE) && (state_nxt == IDLE);
    assign status_nxt = (state_q != END_TAIL) | (tail_nxt != OWT_TAIL_PATTERN) |
                        (crc_calc != o_crc);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_frame_done   <= 1'b0;
            o_frame_status <= 1'b0;
        end else begin
            o_frame_done <= frame_end;
            if (frame_end) begin
                o_frame_status <= status_nxt;
            end
        end
    end

endmodule

// File: rtl/owt_link_monitor.sv
// leaky error counter over frame results, drives the communication-error level
module owt_link_monitor import owt_pkg::*; (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_frame_done,
    input  logic       i_frame_status,
    input  logic       i_comerr_mode,
    input  logic [3:0] i_comerr_config,
    output logic       o_com_err
);

    logic [OWT_ERR_CNT_W-1:0] err_cnt;
    logic [OWT_ERR_CNT_W-1:0] add_step;
    logic [OWT_ERR_CNT_W-1:0] sub_step;
    logic [OWT_ERR_CNT_W:0]   add_sum;
    logic                     com_err_nxt;

    assign add_step = OWT_ERR_ADD_STEP[i_comerr_config[3:2]];
    assign sub_step = OWT_COR_SUB_STEP[i_comerr_config[1:0]];
    // one extra bit to catch overflow
    assign add_sum  = {1'b0, err_cnt} + {1'b0, add_step};

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            err_cnt <= OWT_ERR_INIT;
        end else if (i_frame_done && i_frame_status) begin
            if (add_sum > {1'b0, OWT_ERR_MAX}) begin
                err_cnt <= OWT_ERR_MAX;
            end else begin
                err_cnt <= add_sum[OWT_ERR_CNT_W-1:0];
            end
        end else if (i_frame_done) begin
            // good frame, leak towards zero
            if (sub_step >= err_cnt) begin
                err_cnt <= '0;
            end else begin
                err_cnt <= err_cnt - sub_step;
            end
        end
    end

    // mode 1 flags an empty counter instead
    assign com_err_nxt = i_comerr_mode ? (err_cnt == '0) : (err_cnt >= add_step);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_com_err <= 1'b1;
        end else begin
            o_com_err <= com_err_nxt;
        end
    end

endmodule

// File: rtl/owt_rx_top.sv
// receiver top level, slicer feeding the frame deserializer and the link monitor
module owt_rx_top import owt_pkg::*; (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  logic                     i_rx_line,
    input  logic                     i_comerr_mode,
    input  logic [3:0]               i_comerr_config,
    output logic                     o_frame_vld,
    output logic [OWT_CMD_BITS-1:0]  o_frame_cmd,
    output logic [OWT_DATA_BITS-1:0] o_frame_data,
    output logic [OWT_CRC_BITS-1:0]  o_frame_crc,
    output logic                     o_frame_status,
    output logic                     o_com_err
);

    logic rise;
    logic fall;
    logic sym_vld;
    logic sym_level;
    logic head_phase;

    owt_symbol_slicer slicer_i (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_rx_line    (i_rx_line),
        .i_head_phase (head_phase),
        .o_rise       (rise),
        .o_fall       (fall),
        .o_sym_vld    (sym_vld),
        .o_sym_level  (sym_level)
    );

    owt_frame_deserializer deser_i (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_rise         (rise),
        .i_fall         (fall),
        .i_sym_vld      (sym_vld),
        .i_sym_level    (sym_level),
        .o_head_phase   (head_phase),
        .o_cmd          (o_frame_cmd),
        .o_data         (o_frame_data),
        .o_crc          (o_frame_crc),
        .o_frame_done   (o_frame_vld),
        .o_frame_status (o_frame_status)
    );

    // frame result also feeds the error counter
    owt_link_monitor monitor_i (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_frame_done    (o_frame_vld),
        .i_frame_status  (o_frame_status),
        .i_comerr_mode   (i_comerr_mode),
        .i_comerr_config (i_comerr_config),
        .o_com_err       (o_com_err)
    );

endmodule

// File: tb/owt_rx_checker.sv
// watches the receiver outputs and compares each frame result with the expected entry
module owt_rx_checker import owt_pkg::*; (
    input  logic            i_clk,
    input  logic            i_rst_n,
    input  logic            i_frame_vld,
    input  logic [7:0]      i_frame_cmd,
    input  logic [15:0]     i_frame_data,
    input  logic [7:0]      i_frame_crc,
    input  logic            i_frame_status,
    input  logic            i_com_err,
    input  logic [8*16-1:0] i_exp_name,
    input  logic [7:0]      i_exp_cmd,
    input  logic [15:0]     i_exp_data,
    input  logic [7:0]      i_exp_crc,
    input  logic            i_exp_status,
    input  logic            i_exp_com_err,
    input  logic            i_exp_fields,
    output int              o_checked,
    output int              o_failed
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [8*16-1:0] RESET_NAME = "reset";

    logic ok;

    task automatic check_field(input logic [8*16-1:0] tname, input string label,
                               input logic [31:0] exp_v, input logic [31:0] act_v);
        if (exp_v !== act_v) begin
            $display("CHECK FAILED %0s %0s: expected %0h, actual %0h",
                     tname, label, exp_v, act_v);
            ok = 1'b0;
        end
    endtask

    initial begin
        o_checked = 0;
        o_failed  = 0;
        @(posedge i_rst_n);
        @(posedge i_clk);
        ok = 1'b1;
        check_field(RESET_NAME, "com_err", 32'(1'b1), 32'(i_com_err));
        check_field(RESET_NAME, "frame_vld", 32'(1'b0), 32'(i_frame_vld));
        check_field(RESET_NAME, "status", 32'(1'b0), 32'(i_frame_status));
        if (!ok) begin
            o_failed++;
        end
        forever begin
            @(posedge i_clk);
            if (i_frame_vld) begin
                ok = 1'b1;
                check_field(i_exp_name, "status", 32'(i_exp_status), 32'(i_frame_status));
                if (i_exp_fields) begin
                    check_field(i_exp_name, "cmd", 32'(i_exp_cmd), 32'(i_frame_cmd));
                    check_field(i_exp_name, "data", 32'(i_exp_data), 32'(i_frame_data));
                    check_field(i_exp_name, "crc", 32'(i_exp_crc), 32'(i_frame_crc));
                end
                // valid lasts a single cycle
                @(posedge i_clk);
                check_field(i_exp_name, "frame_vld", 32'(1'b0), 32'(i_frame_vld));
                // error level follows the counter by one edge
                @(posedge i_clk);
                check_field(i_exp_name, "com_err", 32'(i_exp_com_err), 32'(i_com_err));
                if (ok) begin
                    $display("test %0s: ok", i_exp_name);
                end else begin
                    $display("test %0s: failed", i_exp_name);
                    o_failed++;
                end
                o_checked++;
            end
        end
    end

endmodule

// File: tb/owt_rx_tb.sv
// testbench top that drives a table of manchester frames onto the receiver line
module owt_rx_tb import owt_pkg::*;;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_TESTS = 13;

    typedef enum {FAULT_NONE, FAULT_SYNC_TAIL, FAULT_MANCH} fault_e;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        rx_line;
    logic        comerr_mode;
    logic [3:0]  comerr_config;
    logic        frame_vld;
    logic [7:0]  frame_cmd;
    logic [15:0] frame_data;
    logic [7:0]  frame_crc;
    logic        frame_status;
    logic        com_err;

    // frame table
    logic [8*16-1:0] t_name [N_TESTS];
    int              t_h [N_TESTS];
    logic [7:0]      t_cmd [N_TESTS];
    logic [15:0]     t_data [N_TESTS];
    logic            t_crc_bad [N_TESTS];
    fault_e          t_fault [N_TESTS];
    logic [3:0]      t_cfg [N_TESTS];
    logic            t_mode [N_TESTS];
    logic            t_status [N_TESTS];
    logic            t_com_err [N_TESTS];

    logic [8*16-1:0] exp_name;
    logic [7:0]      exp_cmd;
    logic [15:0]     exp_data;
    logic [7:0]      exp_crc;
    logic            exp_status;
    logic            exp_com_err;
    logic            exp_fields;
    int              checked;
    int              failed;
    int              n_added = 0;
    int              cycle_cnt = 0;
    int              timeout_limit;
    logic [31:0]     lfsr_state = 32'h7201_9157;

    always #4 clk = ~clk;

    owt_rx_top dut_i (
        .i_clk           (clk),
        .i_rst_n         (rst_n),
        .i_rx_line       (rx_line),
        .i_comerr_mode   (comerr_mode),
        .i_comerr_config (comerr_config),
        .o_frame_vld     (frame_vld),
        .o_frame_cmd     (frame_cmd),
        .o_frame_data    (frame_data),
        .o_frame_crc     (frame_crc),
        .o_frame_status  (frame_status),
        .o_com_err       (com_err)
    );

    owt_rx_checker checker_i (
        .i_clk          (clk),
        .i_rst_n        (rst_n),
        .i_frame_vld    (frame_vld),
        .i_frame_cmd    (frame_cmd),
        .i_frame_data   (frame_data),
        .i_frame_crc    (frame_crc),
        .i_frame_status (frame_status),
        .i_com_err      (com_err),
        .i_exp_name     (exp_name),
        .i_exp_cmd      (exp_cmd),
        .i_exp_data     (exp_data),
        .i_exp_crc      (exp_crc),
        .i_exp_status   (exp_status),
        .i_exp_com_err  (exp_com_err),
        .i_exp_fields   (exp_fields),
        .o_checked      (checked),
        .o_failed       (failed)
    );

    // ====================
    // helpers
    // ====================
    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic has_data(input logic [7:0] cmd);
        return !(!cmd[7] && (cmd[6:0] == 7'h1F));
    endfunction

    function automatic logic [7:0] frame_crc_of(input logic [7:0] cmd, input logic [15:0] data);
        logic [7:0] crc;
        logic       fb;
        crc = 8'h00;
        for (int b = 23; b >= 0; b--) begin
            if (b >= 16 || has_data(cmd)) begin
                fb  = crc[7] ^ ((b >= 16) ? cmd[b-16] : data[b]);
                crc = {crc[6:0], 1'b0} ^ (fb ? OWT_CRC_POLY : 8'h00);
            end
        end
        return crc;
    endfunction

    task automatic add_test(input logic [8*16-1:0] name, input int h, input logic [7:0] cmd,
                            input logic [15:0] data, input logic rnd, input logic crc_bad,
                            input fault_e fault, input logic mode, input logic status,
                            input logic ce);
        logic [15:0] d;
        d = data;
        if (rnd) begin
            for (int b = 0; b < 16; b++) begin
                lfsr_state = lfsr_next(lfsr_state);
                d = {d[14:0], lfsr_state[0]};
            end
        end
        t_name[n_added]    = name;
        t_h[n_added]       = h;
        t_cmd[n_added]     = cmd;
        t_data[n_added]    = d;
        t_crc_bad[n_added] = crc_bad;
        t_fault[n_added]   = fault;
        t_cfg[n_added]     = 4'b0011;
        t_mode[n_added]    = mode;
        t_status[n_added]  = status;
        t_com_err[n_added] = ce;
        n_added++;
    endtask

    task automatic send_half(input logic lvl, input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            rx_line <= lvl;
        end
    endtask

    task automatic send_bit(input logic b, input int h);
        send_half(b, h);
        send_half(!b, h);
    endtask

    task automatic send_frame(input int idx);
        int         h;
        logic [7:0] crc;
        h   = t_h[idx];
        crc = frame_crc_of(t_cmd[idx], t_data[idx]) ^ (t_crc_bad[idx] ? 8'h01 : 8'h00);
        repeat (OWT_HEAD_PULSES) begin
            send_half(1'b1, h);
            send_half(1'b0, h);
        end
        if (t_fault[idx] == FAULT_SYNC_TAIL) begin
            // tail 0100 and then the line stays low
            send_half(1'b1, h);
            send_half(1'b0, 8 * h);
            return;
        end
        send_half(1'b1, 2 * h);
        send_half(1'b0, h);
        for (int b = 7; b >= 0; b--) begin
            send_bit(t_cmd[idx][b], h);
        end
        if (has_data(t_cmd[idx])) begin
            for (int b = 15; b >= 0; b--) begin
                if (t_fault[idx] == FAULT_MANCH && b == 11) begin
                    // low-low pair and nothing sent after it
                    send_half(1'b0, 10 * h);
                    return;
                end
                send_bit(t_data[idx][b], h);
            end
        end
        for (int b = 7; b >= 0; b--) begin
            send_bit(crc[b], h);
        end
        send_half(1'b0, h);
        send_half(1'b1, 2 * h);
        send_half(1'b0, 5 * h);
    endtask

    // ====================
    // timeout
    // ====================
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == timeout_limit) begin
            $display("timeout: frame results still missing after %0d cycles", cycle_cnt);
            $display("Test failures found");
            $finish;
        end
    end

    // ====================
    // main sequence
    // ====================
    initial begin
        rst_n         = 1'b0;
        rx_line       = 1'b0;
        comerr_mode   = 1'b0;
        comerr_config = 4'b0011;
        // counter starts at 15 with add step 2 and sub step 4
        add_test("wr_h6", 6, 8'h85, 16'hA5C3, 1'b0, 1'b0, FAULT_NONE, 1'b0, 1'b0, 1'b1);
        add_test("rd_nodata", 6, 8'h1F, 16'hA5C3, 1'b0, 1'b0, FAULT_NONE, 1'b0, 1'b0, 1'b1);
        add_test("crc_bad", 6, 8'h92, 16'h1234, 1'b0, 1'b1, FAULT_NONE, 1'b0, 1'b1, 1'b1);
        add_test("sync_tail_bad", 6, 8'h85, 16'h0F0F, 1'b0, 1'b0, FAULT_SYNC_TAIL, 1'b0, 1'b1,
                 1'b1);
        add_test("manch_data", 6, 8'h85, 16'hFFFF, 1'b0, 1'b0, FAULT_MANCH, 1'b0, 1'b1, 1'b1);
        add_test("rand_h6_a", 6, 8'hC4, 16'h0, 1'b1, 1'b0, FAULT_NONE, 1'b0, 1'b0, 1'b1);
        add_test("rand_h9_a", 9, 8'hC4, 16'h0, 1'b1, 1'b0, FAULT_NONE, 1'b0, 1'b0, 1'b1);
        add_test("rand_h6_b", 6, 8'hA7, 16'h0, 1'b1, 1'b0, FAULT_NONE, 1'b0, 1'b0, 1'b0);
        add_test("rand_h9_b", 9, 8'hA7, 16'h0, 1'b1, 1'b0, FAULT_NONE, 1'b0, 1'b0, 1'b0);
        add_test("rand_h6_m1", 6, 8'h81, 16'h0, 1'b1, 1'b0, FAULT_NONE, 1'b1, 1'b0, 1'b1);
        add_test("crc_bad_m1", 9, 8'h81, 16'h5555, 1'b0, 1'b1, FAULT_NONE, 1'b1, 1'b1, 1'b0);
        add_test("rand_h9_m1", 9, 8'h81, 16'h0, 1'b1, 1'b0, FAULT_NONE, 1'b1, 1'b0, 1'b1);
        add_test("rand_h6_m0", 6, 8'h81, 16'h0, 1'b1, 1'b0, FAULT_NONE, 1'b0, 1'b0, 1'b0);
        timeout_limit = 200;
        for (int i = 0; i < N_TESTS; i++) begin
            timeout_limit += 100 * t_h[i];
        end
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        repeat (4) @(posedge clk);
        for (int i = 0; i < N_TESTS; i++) begin
            @(posedge clk);
            comerr_mode   <= t_mode[i];
            comerr_config <= t_cfg[i];
            exp_name      <= t_name[i];
            exp_cmd       <= t_cmd[i];
            exp_data      <= t_data[i];
            exp_crc       <= frame_crc_of(t_cmd[i], t_data[i]);
            exp_status    <= t_status[i];
            exp_com_err   <= t_com_err[i];
            exp_fields    <= !t_status[i];
            send_frame(i);
            while (checked <= i) begin
                @(posedge clk);
            end
        end
        repeat (4) @(posedge clk);
        if (checked != N_TESTS) begin
            $display("wrong number of frame results: %0d for %0d tests", checked, N_TESTS);
        end
        $display("tests run %0d, failures %0d", checked, failed);
        if (failed == 0 && checked == N_TESTS) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: all.f
rtl/owt_pkg.sv
rtl/owt_symbol_slicer.sv
rtl/owt_crc8.sv
rtl/owt_frame_deserializer.sv
rtl/owt_link_monitor.sv
rtl/owt_rx_top.sv
tb/owt_rx_checker.sv
tb/owt_rx_tb.sv

// File: run.sh
#!/bin/sh
verilator --binary --timing -f all.f --top-module owt_rx_tb -o owt_rx_sim &&
./obj_dir/owt_rx_sim | tee /dev/stderr | grep -q "All tests passed!" &&
echo "simulation ok" || { echo "simulation failed"; exit 1; }
